//--- Bender.yml
package:
  name: edge_acc

sources:
  # Shared package first
  - common/edge_pkg.sv
  # Design, leaves before the top level
  - sobel/sobel_lane.sv
  - line_buffer/line_buffer.sv
  - hdl/acc_control.sv
  - hdl/edge_acc.sv
  # Testbench
  - target: simulation
    files:
      - sim/edge_acc_properties.sv
      - sim/tb_edge_acc.sv

//--- common/edge_pkg.sv
// Fixed 16x6 image; LINE_LENGTH must be a multiple of 4 and at least 8, addresses are word addresses
package edge_pkg;

  // ------------------------------------------------------------------------
  // Image geometry
  // ------------------------------------------------------------------------
  localparam int LINE_LENGTH    = 16;                          // Pixels per row
  localparam int LINE_COUNT     = 6;                           // Rows per image
  localparam int PIX_PER_WORD   = 4;                           // Bytes per memory word
  localparam int WORDS_PER_LINE = LINE_LENGTH / PIX_PER_WORD;  // Memory words per row
  localparam int PIX_MAX        = 255;                         // Magnitude clamp

  // ------------------------------------------------------------------------
  // Data types
  // ------------------------------------------------------------------------
  typedef logic [7:0]         pixel_t;  // Unsigned grayscale pixel
  typedef logic [31:0]        word_t;   // Four pixels, byte 0 is leftmost
  typedef logic [15:0]        addr_t;   // Word address
  typedef logic signed [10:0] grad_t;   // Dx or Dy, range +-1020

  // Buffer column, covers both guard columns
  typedef logic [$clog2(LINE_LENGTH + 2)-1:0] col_t;
  typedef logic [1:0]                         slot_t;  // Line buffer slot 0..2
  typedef logic [$clog2(LINE_COUNT + 1)-1:0]  row_t;   // Output row counter

  // ------------------------------------------------------------------------
  // Memory map
  // ------------------------------------------------------------------------
  localparam addr_t SRC_BASE = 16'd0;  // Source image
  // Results follow the source image directly
  localparam addr_t DST_BASE = addr_t'(SRC_BASE + WORDS_PER_LINE * LINE_COUNT);

  // Controller states
  typedef enum logic [2:0] {
    IDLE,       // Wait for start
    LOAD_ROWS,  // Fetch rows 0 and 1
    COMPUTE,    // Step window across one row
    DRAIN,      // Write the last in-flight word of the row
    READ_ROW,   // Fetch next row into the oldest slot
    DONE        // Hold finish until start drops
  } ctrl_state_t;

endpackage

//--- hdl/acc_control.sv
// Needs WORDS_PER_LINE >= 2 so the last pending buffer write never hits the first window of a row
`timescale 1ns/1ps

module acc_control (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  output logic            finish,
  output edge_pkg::addr_t addr,
  output logic            en,
  output logic            we,
  output logic            buf_we,    // Delayed read strobe
  output edge_pkg::slot_t buf_slot,
  output edge_pkg::col_t  buf_col,
  output edge_pkg::col_t  win_col,   // Leftmost output column of the window
  output edge_pkg::slot_t top_slot,
  output edge_pkg::slot_t mid_slot,  // Slot holding the current output row
  output edge_pkg::slot_t bot_slot
);

  edge_pkg::ctrl_state_t state;
  edge_pkg::addr_t       rd_addr;    // Next source word
  edge_pkg::addr_t       wr_addr;    // DST_BASE plus words written
  edge_pkg::col_t        word_idx;   // Word within the row being fetched
  edge_pkg::slot_t       fill_slot;  // Slot the fetch goes to
  edge_pkg::row_t        row;        // Current output row
  logic                  win_valid;  // Window issued last cycle, result due now
  logic                  rd_issue;
  logic                  last_word;
  logic                  last_win;

  // Slot arithmetic modulo 3
  function automatic edge_pkg::slot_t slot_inc(input edge_pkg::slot_t s);
    return (s == 2'd2) ? 2'd0 : s + 2'd1;
  endfunction

  function automatic edge_pkg::slot_t slot_dec(input edge_pkg::slot_t s);
    return (s == 2'd0) ? 2'd2 : s - 2'd1;
  endfunction

  // ------------------------------------------------------------------------
  // Memory port
  // ------------------------------------------------------------------------
  assign rd_issue = (state == edge_pkg::LOAD_ROWS) || (state == edge_pkg::READ_ROW);
  assign we       = win_valid;                        // Result word one cycle behind its window
  assign en       = rd_issue || win_valid;            // Never both in the same cycle
  assign addr     = win_valid ? wr_addr : rd_addr;
  assign finish   = (state == edge_pkg::DONE);

  assign last_word = (word_idx == edge_pkg::col_t'(edge_pkg::WORDS_PER_LINE - 1));
  assign last_win  = (win_col == edge_pkg::col_t'(edge_pkg::LINE_LENGTH - 3));

  // Row clamping: top row is its own upper neighbour, last row its own lower
  assign top_slot = (row == '0) ? mid_slot : slot_dec(mid_slot);
  assign bot_slot = (row == edge_pkg::row_t'(edge_pkg::LINE_COUNT - 1)) ?
                    mid_slot : slot_inc(mid_slot);

  // ------------------------------------------------------------------------
  // Buffer write strobe, aligned to data_r
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      buf_we <= 1'b0;
    end else begin
      buf_we <= rd_issue;
    end
  end

  always_ff @(posedge clk) begin
    buf_slot <= fill_slot;
    buf_col  <= edge_pkg::col_t'(word_idx * edge_pkg::PIX_PER_WORD + 1);  // Skip left guard
  end

  // ------------------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= edge_pkg::IDLE;
      rd_addr   <= edge_pkg::SRC_BASE;
      wr_addr   <= edge_pkg::DST_BASE;
      word_idx  <= '0;
      fill_slot <= '0;
      mid_slot  <= '0;
      row       <= '0;
      win_col   <= edge_pkg::col_t'(1);
      win_valid <= 1'b0;
    end else begin
      win_valid <= (state == edge_pkg::COMPUTE);
      if (win_valid) begin
        wr_addr <= wr_addr + 1'b1;
      end

      case (state)
        edge_pkg::IDLE: begin
          if (start) begin
            // Fresh run, restart all pointers
            state     <= edge_pkg::LOAD_ROWS;
            rd_addr   <= edge_pkg::SRC_BASE;
            wr_addr   <= edge_pkg::DST_BASE;
            word_idx  <= '0;
            fill_slot <= '0;              // Row 0 to slot 0, row 1 to slot 1
            mid_slot  <= '0;
            row       <= '0;
            win_col   <= edge_pkg::col_t'(1);
          end
        end

        edge_pkg::LOAD_ROWS: begin
          rd_addr <= rd_addr + 1'b1;
          if (last_word) begin
            word_idx  <= '0;
            fill_slot <= slot_inc(fill_slot);
            if (fill_slot == 2'd1) begin
              state <= edge_pkg::COMPUTE;  // Both rows fetched
            end
          end else begin
            word_idx <= word_idx + 1'b1;
          end
        end

        edge_pkg::COMPUTE: begin
          if (last_win) begin
            state <= edge_pkg::DRAIN;
          end else begin
            win_col <= win_col + edge_pkg::col_t'(edge_pkg::PIX_PER_WORD);
          end
        end

        edge_pkg::DRAIN: begin
          win_col <= edge_pkg::col_t'(1);
          if (row == edge_pkg::row_t'(edge_pkg::LINE_COUNT - 1)) begin
            state <= edge_pkg::DONE;
          end else begin
            // Rotate roles; the old top slot becomes the new bottom
            row       <= row + 1'b1;
            mid_slot  <= slot_inc(mid_slot);
            fill_slot <= slot_dec(mid_slot);
            // Last row reuses its own data as lower neighbour, no fetch
            if (row == edge_pkg::row_t'(edge_pkg::LINE_COUNT - 2)) begin
              state <= edge_pkg::COMPUTE;
            end else begin
              state <= edge_pkg::READ_ROW;
            end
          end
        end

        edge_pkg::READ_ROW: begin
          rd_addr <= rd_addr + 1'b1;
          if (last_word) begin
            word_idx <= '0;
            state    <= edge_pkg::COMPUTE;
          end else begin
            word_idx <= word_idx + 1'b1;
          end
        end

        edge_pkg::DONE: begin
          if (!start) begin
            state <= edge_pkg::IDLE;     // Four-phase release
          end
        end

        default: state <= edge_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- hdl/edge_acc.sv
// Memory is assumed always ready with one cycle read latency; start must stay high until finish
`timescale 1ns/1ps

module edge_acc (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,   // Request, held by host
  output logic            finish,  // Acknowledge
  output edge_pkg::addr_t addr,
  output logic            en,
  output logic            we,
  output edge_pkg::word_t data_w,
  input  edge_pkg::word_t data_r
);

  // Line buffer write side
  logic            buf_we;
  edge_pkg::slot_t buf_slot;
  edge_pkg::col_t  buf_col;

  // Window read side
  edge_pkg::col_t  win_col;
  edge_pkg::slot_t top_slot;
  edge_pkg::slot_t mid_slot;
  edge_pkg::slot_t bot_slot;

  // 3 rows by (PIX_PER_WORD + 2) columns, row major
  edge_pkg::pixel_t window [3 * (edge_pkg::PIX_PER_WORD + 2)];
  edge_pkg::pixel_t lane_pix [edge_pkg::PIX_PER_WORD];

  acc_control u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .finish   (finish),
    .addr     (addr),
    .en       (en),
    .we       (we),
    .buf_we   (buf_we),
    .buf_slot (buf_slot),
    .buf_col  (buf_col),
    .win_col  (win_col),
    .top_slot (top_slot),
    .mid_slot (mid_slot),
    .bot_slot (bot_slot)
  );

  line_buffer u_lbuf (
    .clk      (clk),
    .buf_we   (buf_we),
    .buf_slot (buf_slot),
    .buf_col  (buf_col),
    .data_r   (data_r),
    .win_col  (win_col),
    .top_slot (top_slot),
    .mid_slot (mid_slot),
    .bot_slot (bot_slot),
    .window   (window)
  );

  // ------------------------------------------------------------------------
  // Four lanes, lane j centred on window column j+1
  // ------------------------------------------------------------------------
  for (genvar j = 0; j < edge_pkg::PIX_PER_WORD; j++) begin : g_lane
    localparam int S = edge_pkg::PIX_PER_WORD + 2;  // Row stride in window

    sobel_lane u_lane (
      .clk   (clk),
      .reset (reset),
      .p11   (window[j]),          .p12 (window[j + 1]),          .p13 (window[j + 2]),
      .p21   (window[S + j]),      .p22 (window[S + j + 1]),      .p23 (window[S + j + 2]),
      .p31   (window[2 * S + j]),  .p32 (window[2 * S + j + 1]),  .p33 (window[2 * S + j + 2]),
      .pix   (lane_pix[j])
    );

    assign data_w[8*j +: 8] = lane_pix[j];  // Lane 0 to least significant byte
  end

endmodule

//--- line_buffer/line_buffer.sv
// Holds three rows plus one guard column each side; write lands next cycle, window read is combinational
`timescale 1ns/1ps

module line_buffer (
  input  logic             clk,
  input  logic             buf_we,
  input  edge_pkg::slot_t  buf_slot,  // 0..2 only
  input  edge_pkg::col_t   buf_col,   // First data column of the word
  input  edge_pkg::word_t  data_r,
  input  edge_pkg::col_t   win_col,
  input  edge_pkg::slot_t  top_slot,
  input  edge_pkg::slot_t  mid_slot,
  input  edge_pkg::slot_t  bot_slot,
  output edge_pkg::pixel_t window [3 * (edge_pkg::PIX_PER_WORD + 2)]
);

  // Column 0 and LINE_LENGTH+1 are the replicated border pixels
  edge_pkg::pixel_t rows [3][edge_pkg::LINE_LENGTH + 2];
  edge_pkg::slot_t  sel  [3];

  assign sel[0] = top_slot;
  assign sel[1] = mid_slot;
  assign sel[2] = bot_slot;

  // ------------------------------------------------------------------------
  // Word write with border replication
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (buf_we) begin
      for (int b = 0; b < edge_pkg::PIX_PER_WORD; b++) begin
        rows[buf_slot][buf_col + b] <= data_r[8*b +: 8];  // Byte 0 leftmost
      end
      // First word of the row also fills the left guard
      if (buf_col == edge_pkg::col_t'(1)) begin
        rows[buf_slot][0] <= data_r[7:0];
      end
      // Last word fills the right guard
      if (buf_col == edge_pkg::col_t'(edge_pkg::LINE_LENGTH - 3)) begin
        rows[buf_slot][edge_pkg::LINE_LENGTH + 1] <= data_r[31:24];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Window read, six columns from win_col-1 in each selected row
  // ------------------------------------------------------------------------
  for (genvar r = 0; r < 3; r++) begin : g_row
    for (genvar c = 0; c < edge_pkg::PIX_PER_WORD + 2; c++) begin : g_col
      assign window[r * (edge_pkg::PIX_PER_WORD + 2) + c] = rows[sel[r]][win_col + c - 1];
    end
  end

endmodule

//--- sim/edge_acc_properties.sv
// Bound into every edge_acc instance; checks hold only while reset is low
`timescale 1ns/1ps

module edge_acc_properties (
  input logic            clk,
  input logic            reset,
  input logic            start,
  input logic            finish,
  input logic            en,
  input logic            we,
  input edge_pkg::addr_t addr
);

  // Top of the result region, exclusive
  localparam int DST_END = int'(edge_pkg::DST_BASE)
                         + edge_pkg::WORDS_PER_LINE * edge_pkg::LINE_COUNT;

  int fail_count = 0;  // Failed assertions so far

  // --------------------------------------------------------------------------
  // Memory port
  // --------------------------------------------------------------------------
  a_we_needs_en : assert property (@(posedge clk) disable iff (reset) we |-> en)
    else begin
      $error("we asserted without en");
      fail_count++;
    end

  a_quiet_when_done : assert property (@(posedge clk) disable iff (reset) finish |-> !en)
    else begin
      $error("memory access while finish is high");
      fail_count++;
    end

  a_write_in_dst : assert property (@(posedge clk) disable iff (reset)
    (en && we) |-> (int'(addr) >= int'(edge_pkg::DST_BASE) && int'(addr) < DST_END))
    else begin
      $error("write outside result region");
      fail_count++;
    end

  // --------------------------------------------------------------------------
  // Four-phase handshake
  // --------------------------------------------------------------------------
  a_finish_release : assert property (@(posedge clk) disable iff (reset)
    $fell(finish) |-> !$past(start))
    else begin
      $error("finish dropped while start still high");
      fail_count++;
    end

  a_finish_on_req : assert property (@(posedge clk) disable iff (reset) $rose(finish) |-> start)
    else begin
      $error("finish rose without a pending start");
      fail_count++;
    end

endmodule

bind edge_acc edge_acc_properties u_props (
  .clk    (clk),
  .reset  (reset),
  .start  (start),
  .finish (finish),
  .en     (en),
  .we     (we),
  .addr   (addr)
);

//--- sim/tb_edge_acc.sv
// Memory model answers reads one cycle after en, images are 16x6 from the package, runs are serial
`timescale 1ns/1ps

module tb_edge_acc;

  localparam int NUM_WORDS = edge_pkg::WORDS_PER_LINE * edge_pkg::LINE_COUNT;  // Per image
  localparam int MEM_WORDS = int'(edge_pkg::DST_BASE) + NUM_WORDS;
  localparam int TIMEOUT   = 1000;  // Cycles per wait
  localparam int NUM_CASES = 6;

  typedef enum logic [1:0] {PAT_CONST, PAT_VSTEP, PAT_HSTEP, PAT_RAND} pattern_t;
  typedef struct packed {
    pattern_t kind;
    int       lv_a;   // Base level, or low bound for random
    int       lv_b;   // Second level, or high bound for random
  } case_t;

  // Stimulus table
  case_t cases [NUM_CASES] = '{
    '{PAT_CONST, 77, 77},    // Flat image
    '{PAT_VSTEP, 0, 200},    // Left dark, right bright
    '{PAT_HSTEP, 20, 60},    // Brighter top and bottom rows plus ramp, stays below clamp
    '{PAT_RAND, 0, 255},     // Full range noise
    '{PAT_VSTEP, 200, 10},   // Falling step, second run after handshake
    '{PAT_RAND, 100, 140}    // Low contrast, mostly below clamp
  };

  logic             clk;
  logic             reset;
  logic             start;
  logic             finish;
  logic             en;
  logic             we;
  edge_pkg::addr_t  addr;
  edge_pkg::word_t  data_w;
  edge_pkg::word_t  data_r;

  edge_pkg::word_t  mem [MEM_WORDS];
  edge_pkg::pixel_t img [edge_pkg::LINE_COUNT][edge_pkg::LINE_LENGTH];  // Reference copy
  logic [31:0]      rng_state;

  edge_acc u_edge_acc (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .finish (finish),
    .addr   (addr),
    .en     (en),
    .we     (we),
    .data_w (data_w),
    .data_r (data_r)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  // --------------------------------------------------------------------------
  // Memory model, synchronous write, read data one cycle later
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (en && we && int'(addr) < MEM_WORDS) begin
      mem[addr] <= data_w;
    end
    if (en && !we) begin
      data_r <= (int'(addr) < MEM_WORDS) ? mem[addr] : 'x;  // Out of map reads poison
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // --------------------------------------------------------------------------
  // Reference model with replicated borders and clamp
  // --------------------------------------------------------------------------
  function automatic int pix_at(input int r, input int c);
    int rr;
    int cc;
    rr = (r < 0) ? 0 : (r >= edge_pkg::LINE_COUNT) ? edge_pkg::LINE_COUNT - 1 : r;
    cc = (c < 0) ? 0 : (c >= edge_pkg::LINE_LENGTH) ? edge_pkg::LINE_LENGTH - 1 : c;
    return int'(img[rr][cc]);
  endfunction

  function automatic edge_pkg::pixel_t sobel_ref(input int r, input int c);
    int dx;
    int dy;
    int m;
    dx = (pix_at(r - 1, c + 1) + 2 * pix_at(r, c + 1) + pix_at(r + 1, c + 1))
       - (pix_at(r - 1, c - 1) + 2 * pix_at(r, c - 1) + pix_at(r + 1, c - 1));
    dy = (pix_at(r - 1, c - 1) + 2 * pix_at(r - 1, c) + pix_at(r - 1, c + 1))
       - (pix_at(r + 1, c - 1) + 2 * pix_at(r + 1, c) + pix_at(r + 1, c + 1));
    m = ((dx < 0) ? -dx : dx) + ((dy < 0) ? -dy : dy);
    if (m > edge_pkg::PIX_MAX) begin
      m = edge_pkg::PIX_MAX;  // Saturate
    end
    return edge_pkg::pixel_t'(m);
  endfunction

  function automatic edge_pkg::word_t exp_word(input int r, input int w);
    edge_pkg::word_t v;
    for (int j = 0; j < edge_pkg::PIX_PER_WORD; j++) begin
      v[8*j +: 8] = sobel_ref(r, w * edge_pkg::PIX_PER_WORD + j);  // Leftmost pixel in byte 0
    end
    return v;
  endfunction

  function automatic edge_pkg::word_t src_word(input int r, input int w);
    edge_pkg::word_t v;
    for (int j = 0; j < edge_pkg::PIX_PER_WORD; j++) begin
      v[8*j +: 8] = img[r][w * edge_pkg::PIX_PER_WORD + j];
    end
    return v;
  endfunction

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic check_word(input edge_pkg::word_t got, input edge_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s: got %08h, expected %08h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Word mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Flag mismatch");
    end
  endtask

  // Poll finish on falling edges until it reaches the level
  task automatic wait_finish(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (finish !== level && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (finish !== level) begin
      $display("Timeout after %0d cycles while waiting for %s", TIMEOUT, what);
      $display("*** TEST FAILED ***");
      $fatal(1, "Handshake timeout");
    end
  endtask

  // Build the image, load the source region and poison the results
  task automatic fill_image(input case_t tc);
    int v;
    for (int r = 0; r < edge_pkg::LINE_COUNT; r++) begin
      for (int c = 0; c < edge_pkg::LINE_LENGTH; c++) begin
        case (tc.kind)
          PAT_CONST: v = tc.lv_a;
          PAT_VSTEP: v = (c < edge_pkg::LINE_LENGTH / 2) ? tc.lv_a : tc.lv_b;
          PAT_HSTEP: v = ((r == 0 || r == edge_pkg::LINE_COUNT - 1) ? tc.lv_b : tc.lv_a) + 2 * c;
          default: begin
            rng_state = lcg_next(rng_state);
            v = tc.lv_a + int'(rng_state[23:16]) % (tc.lv_b - tc.lv_a + 1);
          end
        endcase
        img[r][c] = edge_pkg::pixel_t'(v);
      end
    end
    for (int r = 0; r < edge_pkg::LINE_COUNT; r++) begin
      for (int w = 0; w < edge_pkg::WORDS_PER_LINE; w++) begin
        mem[int'(edge_pkg::SRC_BASE) + r * edge_pkg::WORDS_PER_LINE + w] = src_word(r, w);
      end
    end
    for (int a = int'(edge_pkg::DST_BASE); a < MEM_WORDS; a++) begin
      mem[a] = {16'hdead, edge_pkg::addr_t'(a)};  // Poison tagged with its address
    end
  endtask

  // One full four-phase run and result comparison
  task automatic run_case(input int idx);
    int a;
    fill_image(cases[idx]);
    @(negedge clk);
    start = 1'b1;
    wait_finish(1'b1, "finish to rise");
    repeat (3) begin
      @(negedge clk);
      check_flag(finish, 1'b1, $sformatf("case %0d finish held while start high", idx));
    end
    start = 1'b0;
    wait_finish(1'b0, "finish to fall after start drop");
    @(negedge clk);
    check_flag(finish, 1'b0, $sformatf("case %0d finish stays low after release", idx));
    for (int r = 0; r < edge_pkg::LINE_COUNT; r++) begin
      for (int w = 0; w < edge_pkg::WORDS_PER_LINE; w++) begin
        a = r * edge_pkg::WORDS_PER_LINE + w;
        check_word(mem[int'(edge_pkg::DST_BASE) + a], exp_word(r, w),
                   $sformatf("case %0d result row %0d word %0d", idx, r, w));
        check_word(mem[int'(edge_pkg::SRC_BASE) + a], src_word(r, w),
                   $sformatf("case %0d source row %0d word %0d", idx, r, w));
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    reset     = 1'b1;
    start     = 1'b0;
    data_r    = '0;
    rng_state = 32'd44;  // LCG seed
    repeat (4) @(negedge clk);
    reset = 1'b0;
    check_flag(finish, 1'b0, "finish after reset");
    for (int n = 0; n < NUM_CASES; n++) begin
      run_case(n);
    end
    if (u_edge_acc.u_props.fail_count != 0) begin
      $display("Bound checker saw %0d assertion failures", u_edge_acc.u_props.fail_count);
      $display("*** TEST FAILED ***");
      $fatal(1, "Assertion failures");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- sobel/sobel_lane.sv
// Inputs must be stable in the issue cycle; pix is valid exactly one cycle later
`timescale 1ns/1ps

module sobel_lane (
  input  logic             clk,
  input  logic             reset,
  input  edge_pkg::pixel_t p11,  // Top row, left to right
  input  edge_pkg::pixel_t p12,
  input  edge_pkg::pixel_t p13,
  input  edge_pkg::pixel_t p21,  // Centre row
  input  edge_pkg::pixel_t p22,
  input  edge_pkg::pixel_t p23,
  input  edge_pkg::pixel_t p31,  // Bottom row
  input  edge_pkg::pixel_t p32,
  input  edge_pkg::pixel_t p33,
  output edge_pkg::pixel_t pix
);

  edge_pkg::pixel_t nb [3][3];  // Neighbourhood [row][col]
  edge_pkg::grad_t  dx;
  edge_pkg::grad_t  dy;
  edge_pkg::grad_t  dx_q;
  edge_pkg::grad_t  dy_q;
  logic [10:0]      abs_dx;
  logic [10:0]      abs_dy;
  logic [11:0]      mag;          // Max 2040

  assign nb = '{'{p11, p12, p13}, '{p21, p22, p23}, '{p31, p32, p33}};

  // ------------------------------------------------------------------------
  // Gradients, centre pixel has weight zero in both kernels
  // ------------------------------------------------------------------------
  always_comb begin
    dx = '0;
    dy = '0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        // Dx: right minus left, centre row doubled
        dx = dx + edge_pkg::grad_t'((c - 1) * ((r == 1) ? 2 : 1) * int'(nb[r][c]));
        // Dy: top minus bottom, centre column doubled
        dy = dy + edge_pkg::grad_t'((1 - r) * ((c == 1) ? 2 : 1) * int'(nb[r][c]));
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dx_q <= '0;
      dy_q <= '0;
    end else begin
      dx_q <= dx;
      dy_q <= dy;
    end
  end

  // |Dx| + |Dy| saturated
  assign abs_dx = dx_q[10] ? -dx_q : dx_q;
  assign abs_dy = dy_q[10] ? -dy_q : dy_q;
  assign mag    = {1'b0, abs_dx} + {1'b0, abs_dy};
  assign pix    = (mag > 12'(edge_pkg::PIX_MAX)) ? edge_pkg::pixel_t'(edge_pkg::PIX_MAX) : mag[7:0];

endmodule

//--- vlog.f
common/edge_pkg.sv
sobel/sobel_lane.sv
line_buffer/line_buffer.sv
hdl/acc_control.sv
hdl/edge_acc.sv
sim/edge_acc_properties.sv
sim/tb_edge_acc.sv
